/* rtl/rv_pkg.sv */
package rv_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // RV32I major opcodes, taken from instr[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B // B operand straight through, for LUI
    } alu_op_e;

    // Instruction sequencing states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } ctrl_state_e;

endpackage

/* rtl/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output logic            op_writes_rf_o,
    output logic            op_reads_rf1_o,
    output logic            op_reads_rf2_o,
    output logic            is_load_op_o,
    output logic            is_store_op_o,
    output logic            is_byte_op_o,
    output logic            is_hex_op_o,
    output logic            is_load_unsigned_o,
    output logic            is_branch_op_o,
    output logic            is_jump_op_o,
    output logic            op_is_auipc_o,
    output logic            uses_imm_o,
    output logic            is_halt_o,
    output alu_op_e         alu_op_o,
    output logic [XLEN-1:0] imm_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       is_mem_op;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    // Instruction class flags
    assign op_writes_rf_o = opcode inside {LUI, AUIPC, JAL, JALR, LOAD, OP, OP_IMM};
    assign op_reads_rf1_o = opcode inside {JALR, BRANCH, LOAD, STORE, OP, OP_IMM};
    assign op_reads_rf2_o = opcode inside {BRANCH, STORE, OP};
    assign uses_imm_o     = opcode inside {LUI, AUIPC, JAL, JALR, LOAD, STORE, OP_IMM};
    assign is_load_op_o   = (opcode == LOAD);
    assign is_store_op_o  = (opcode == STORE);
    assign is_branch_op_o = (opcode == BRANCH);
    assign is_jump_op_o   = opcode inside {JAL, JALR};
    assign op_is_auipc_o  = (opcode == AUIPC);
    assign is_mem_op      = is_load_op_o || is_store_op_o;

    // Access size and sign only mean something for memory ops
    assign is_byte_op_o       = (funct3[1:0] == 2'b00) && is_mem_op;
    assign is_hex_op_o        = (funct3[1:0] == 2'b01) && is_mem_op;
    assign is_load_unsigned_o = funct3[2] && is_load_op_o;

    always_comb begin
        unique case (opcode)
            LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP:
                is_halt_o = 1'b0;
            // ECALL, and everything else under SYSTEM, stops the core
            SYSTEM:
                is_halt_o = 1'b1;
            default:
                is_halt_o = 1'b1;
        endcase
    end

    always_comb begin
        unique case (opcode)
            LUI, AUIPC: imm_o = {instr_i[31:12], 12'b0};
            JAL:    imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            BRANCH: imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            STORE:  imm_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            default: imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
        endcase
    end

    // Address, link and branch target arithmetic all use ADD
    always_comb begin
        alu_op_o = ADD;
        if (opcode == LUI) begin
            alu_op_o = PASS_B;
        end else if (opcode == OP || opcode == OP_IMM) begin
            unique case (funct3)
                3'b000: alu_op_o = (opcode == OP && instr_i[30]) ? SUB : ADD;
                3'b001: alu_op_o = SLL;
                3'b010: alu_op_o = SLT;
                3'b011: alu_op_o = SLTU;
                3'b100: alu_op_o = XOR;
                3'b101: alu_op_o = instr_i[30] ? SRA : SRL;
                3'b110: alu_op_o = OR;
                3'b111: alu_op_o = AND;
            endcase
        end
    end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata1_o,
    output logic [XLEN-1:0] rdata2_o
);

    // No storage behind x0
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e         alu_op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    input  logic [2:0]      funct3_i,
    output logic            br_taken_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        unique case (alu_op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt;
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, lt_u};
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = $unsigned($signed(a_i) >>> shamt);
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            PASS_B:  result_o = b_i;
            default: result_o = '0;
        endcase
    end

    // Branch condition on the same operands, BEQ through BGEU
    always_comb begin
        unique case (funct3_i)
            3'b000:  br_taken_o = (a_i == b_i);
            3'b001:  br_taken_o = (a_i != b_i);
            3'b100:  br_taken_o = lt_s;
            3'b101:  br_taken_o = !lt_s;
            3'b110:  br_taken_o = lt_u;
            3'b111:  br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

/* rtl/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            fetch_req_i,
    input  logic            mem_req_i,
    input  logic            we_i,
    input  logic            is_byte_i,
    input  logic            is_hex_i,
    input  logic            is_unsigned_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            done_o,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [XLEN-1:0] wb_adr_o,
    output logic [XLEN-1:0] wb_dat_o,
    output logic [3:0]      wb_sel_o,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack_i
);

    logic            req;
    logic            cyc_q;
    logic            byte_q;
    logic            hex_q;
    logic            unsigned_q;
    logic [1:0]      lane_q;
    logic [XLEN-1:0] lane_data;

    assign req      = fetch_req_i || mem_req_i;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign done_o   = cyc_q && wb_ack_i;

    // A request arriving with ack starts the next cycle straight away
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cyc_q   <= 1'b0;
            wb_we_o <= 1'b0;
        end else if (req) begin
            cyc_q   <= 1'b1;
            wb_we_o <= mem_req_i && we_i;
        end else if (done_o) begin
            cyc_q   <= 1'b0;
            wb_we_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_adr_o   <= {addr_i[XLEN-1:2], 2'b00};
            lane_q     <= addr_i[1:0];
            byte_q     <= mem_req_i && is_byte_i;
            hex_q      <= mem_req_i && is_hex_i;
            unsigned_q <= is_unsigned_i;
            // Fetches come through here as full words
            if (mem_req_i && is_byte_i) begin
                wb_dat_o <= {4{wdata_i[7:0]}};
                wb_sel_o <= 4'b0001 << addr_i[1:0];
            end else if (mem_req_i && is_hex_i) begin
                wb_dat_o <= {2{wdata_i[15:0]}};
                wb_sel_o <= addr_i[1] ? 4'b1100 : 4'b0011;
            end else begin
                wb_dat_o <= wdata_i;
                wb_sel_o <= 4'b1111;
            end
        end
    end

    // Bring the addressed lane down to bit 0, then extend
    assign lane_data = wb_dat_i >> {lane_q, 3'b000};

    always_comb begin
        if (byte_q) begin
            rdata_o = {{(XLEN-8){lane_data[7] && !unsigned_q}}, lane_data[7:0]};
        end else if (hex_q) begin
            rdata_o = {{(XLEN-16){lane_data[15] && !unsigned_q}}, lane_data[15:0]};
        end else begin
            rdata_o = wb_dat_i;
        end
    end

endmodule

/* rtl/rv_control.sv */
`timescale 1ns/1ps

module rv_control import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            lsu_done_i,
    input  logic            br_taken_i,
    input  logic [XLEN-1:0] lsu_rdata_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            op_writes_rf_i,
    input  logic            op_reads_rf1_i,
    input  logic            is_load_op_i,
    input  logic            is_store_op_i,
    input  logic            is_branch_op_i,
    input  logic            is_jump_op_i,
    input  logic            op_is_auipc_i,
    input  logic            uses_imm_i,
    input  logic            is_halt_i,
    output logic [XLEN-1:0] instr_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] rf_wdata_o,
    output logic            fetch_req_o,
    output logic            mem_req_o,
    output logic            rf_we_o,
    output logic            halt_o,
    output logic            alu_a_sel_o,
    output logic            alu_b_sel_o
);

    ctrl_state_e     state_q;
    logic            boot_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] ir_q;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            is_jal;
    logic            is_mem;

    assign pc_plus4 = pc_q + XLEN'(4);
    assign is_jal   = is_jump_op_i && !op_reads_rf1_i;
    assign is_mem   = is_load_op_i || is_store_op_i;

    // Jump targets lose bit 0, which only matters for JALR
    always_comb begin
        if (is_jump_op_i) begin
            next_pc = {alu_result_i[XLEN-1:1], 1'b0};
        end else if (is_branch_op_i && br_taken_i) begin
            next_pc = result_q;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // In DECODE the ALU forms PC + imm, kept as a possible branch target
    assign alu_a_sel_o = (state_q == DECODE) || op_is_auipc_i || is_jal;
    assign alu_b_sel_o = (state_q == DECODE) || uses_imm_i;

    // Requests go out one cycle ahead so the bus is busy from the first FETCH cycle
    assign fetch_req_o = (state_q == FETCH && boot_q) || (state_q == WRITEBACK)
                       || (state_q == MEMORY && lsu_done_i && is_store_op_i);
    assign mem_req_o   = (state_q == EXECUTE) && is_mem;
    assign rf_we_o     = (state_q == WRITEBACK) && op_writes_rf_i;
    assign halt_o      = (state_q == HALT);
    assign instr_o     = ir_q;
    assign pc_o        = pc_q;
    assign rf_wdata_o  = result_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FETCH;
            boot_q  <= 1'b1;
            pc_q    <= RESET_PC;
        end else begin
            boot_q <= 1'b0;
            unique case (state_q)
                FETCH:     if (lsu_done_i) state_q <= DECODE;
                DECODE:    state_q <= is_halt_i ? HALT : EXECUTE;
                EXECUTE: begin
                    pc_q    <= next_pc;
                    state_q <= is_mem ? MEMORY : WRITEBACK;
                end
                MEMORY:    if (lsu_done_i) state_q <= is_store_op_i ? FETCH : WRITEBACK;
                WRITEBACK: state_q <= FETCH;
                HALT:      state_q <= HALT;
                default:   state_q <= HALT;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FETCH && lsu_done_i) begin
            ir_q <= lsu_rdata_i;
        end
        if (state_q == DECODE) begin
            result_q <= alu_result_i;
        end else if (state_q == EXECUTE) begin
            result_q <= is_jump_op_i ? pc_plus4 : alu_result_i;
        end else if (state_q == MEMORY && lsu_done_i && is_load_op_i) begin
            result_q <= lsu_rdata_i;
        end
    end

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [XLEN-1:0] wb_adr_o,
    output logic [XLEN-1:0] wb_dat_o,
    output logic [3:0]      wb_sel_o,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack_i,
    output logic            halt_o
);

    logic [XLEN-1:0] instr, pc, imm, rf_wdata, rdata1, rdata2;
    logic [XLEN-1:0] alu_a, alu_b, alu_result, lsu_addr, lsu_rdata;
    logic [4:0]      rs1, rs2;
    logic            op_writes_rf, op_reads_rf1, op_reads_rf2, is_load_op, is_store_op;
    logic            is_byte_op, is_hex_op, is_load_unsigned, is_branch_op, is_jump_op;
    logic            op_is_auipc, uses_imm, is_halt, fetch_req, mem_req, rf_we;
    logic            alu_a_sel, alu_b_sel, lsu_done, br_taken;
    alu_op_e         alu_op;

    // Unused register ports read x0
    assign rs1      = op_reads_rf1 ? instr[19:15] : 5'd0;
    assign rs2      = op_reads_rf2 ? instr[24:20] : 5'd0;
    assign alu_a    = alu_a_sel ? pc : rdata1;
    assign alu_b    = alu_b_sel ? imm : rdata2;
    assign lsu_addr = fetch_req ? pc : alu_result;

    rv_control #(.RESET_PC(RESET_PC)) rv_control_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .lsu_done_i(lsu_done), .br_taken_i(br_taken),
        .lsu_rdata_i(lsu_rdata), .alu_result_i(alu_result), .op_writes_rf_i(op_writes_rf),
        .op_reads_rf1_i(op_reads_rf1), .is_load_op_i(is_load_op), .is_store_op_i(is_store_op),
        .is_branch_op_i(is_branch_op), .is_jump_op_i(is_jump_op), .op_is_auipc_i(op_is_auipc),
        .uses_imm_i(uses_imm), .is_halt_i(is_halt), .instr_o(instr), .pc_o(pc),
        .rf_wdata_o(rf_wdata), .fetch_req_o(fetch_req), .mem_req_o(mem_req), .rf_we_o(rf_we),
        .halt_o(halt_o), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel)
    );

    rv_decode rv_decode_inst (
        .instr_i(instr), .op_writes_rf_o(op_writes_rf), .op_reads_rf1_o(op_reads_rf1),
        .op_reads_rf2_o(op_reads_rf2), .is_load_op_o(is_load_op), .is_store_op_o(is_store_op),
        .is_byte_op_o(is_byte_op), .is_hex_op_o(is_hex_op),
        .is_load_unsigned_o(is_load_unsigned), .is_branch_op_o(is_branch_op),
        .is_jump_op_o(is_jump_op), .op_is_auipc_o(op_is_auipc), .uses_imm_o(uses_imm),
        .is_halt_o(is_halt), .alu_op_o(alu_op), .imm_o(imm)
    );

    rv_regfile rv_regfile_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .rs1_i(rs1), .rs2_i(rs2), .rd_i(instr[11:7]),
        .we_i(rf_we), .wdata_i(rf_wdata), .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    rv_alu rv_alu_inst (
        .alu_op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result),
        .funct3_i(instr[14:12]), .br_taken_o(br_taken)
    );

    rv_lsu rv_lsu_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .fetch_req_i(fetch_req), .mem_req_i(mem_req),
        .we_i(is_store_op), .is_byte_i(is_byte_op), .is_hex_i(is_hex_op),
        .is_unsigned_i(is_load_unsigned), .addr_i(lsu_addr), .wdata_i(rdata2),
        .rdata_o(lsu_rdata), .done_o(lsu_done), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o),
        .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
    );

endmodule

/* verification/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model import rv_pkg::*; #(
    parameter int WORDS = 256
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [1:0]      max_wait_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  logic [XLEN-1:0] wb_adr_i,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic [3:0]      wb_sel_i,
    output logic [XLEN-1:0] wb_dat_o,
    output logic            wb_ack_o
);

    // Preloaded by the testbench while reset is held
    logic [XLEN-1:0] mem [0:WORDS-1];
    int              seed = 32'h31a4_12d6;
    int              wait_cnt;
    logic [7:0]      idx;

    assign idx = wb_adr_i[9:2];

    // Registered ack, wait states drawn once per access
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wait_cnt <= 0;
        end else begin
            wb_ack_o <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                if (wait_cnt == 0) begin
                    wb_ack_o <= 1'b1;
                    wb_dat_o <= mem[idx];
                    for (int b = 0; b < 4; b++) begin
                        if (wb_we_i && wb_sel_i[b]) begin
                            mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
                        end
                    end
                    wait_cnt <= {$random(seed)} % (max_wait_i + 1);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

/* verification/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker import rv_pkg::*; (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            wb_cyc_o,
    input logic            wb_stb_o,
    input logic            wb_we_o,
    input logic [XLEN-1:0] wb_adr_o,
    input logic [XLEN-1:0] wb_dat_o,
    input logic [3:0]      wb_sel_o,
    input logic            wb_ack_i,
    input logic            halt_o
);

    int unsigned fail_count = 0;

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o |-> wb_cyc_o)
        else begin fail_count++; $error("Wishbone stb high without cyc"); end

    // Request fields hold until the slave acks
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_sel_o)
                                  && $stable(wb_we_o) && $stable(wb_dat_o))
        else begin fail_count++; $error("Wishbone request changed before ack"); end

    a_idle_in_halt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halt_o |-> !wb_cyc_o)
        else begin fail_count++; $error("Bus cycle while halted"); end

    a_halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halt_o |=> halt_o)
        else begin fail_count++; $error("halt_o fell without reset"); end

endmodule

bind rv_core_top rv_core_checker rv_core_checker_inst (.*);

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_NS = 8;
    localparam int WATCHDOG_NS = 5 * 200 * 12 * CLK_NS;
    localparam logic [31:0] SLOT_BASE = 32'h300;
    localparam logic [31:0] STORE_BASE = 32'h380;
    localparam logic [31:0] LOAD_ADDR = 32'h3f0;
    localparam logic [31:0] LOAD_WORD = 32'h80f1_7f82;
    localparam logic [31:0] ECALL = 32'h0000_0073;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    logic        clk_i;
    logic        rst_n_i;
    logic [1:0]  max_wait;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, halt_o;
    logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
    logic [3:0]  wb_sel;

    logic [31:0] prog[$];
    logic [31:0] chk_addr[$];
    logic [31:0] chk_exp[$];
    string       chk_name[$];
    int          err_count;
    int          pass_tests;
    int          fail_tests;

    rv_core_top #(.RESET_PC(32'h0)) rv_core_top_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb),
        .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel),
        .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack), .halt_o(halt_o)
    );

    wb_mem_model wb_mem_model_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .max_wait_i(max_wait), .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_sel_i(wb_sel), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the core never halted within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill_word(logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, i + 8'h3c};
    endfunction

    // Load result with the lane shifted down and then sign or zero extended
    function automatic logic [31:0] load_value(logic [31:0] w, int off, logic [2:0] f3);
        logic [31:0] s;
        s = w >> (8 * off);
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'b0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            2'b01:   return f3[2] ? {16'b0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic bit branch_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic int total_errors();
        return err_count + rv_core_top_inst.rv_core_checker_inst.fail_count;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] exp, input string name);
        chk_addr.push_back(addr);
        chk_exp.push_back(exp);
        chk_name.push_back(name);
    endtask

    // Store a register into the next result slot
    task automatic store_result(input logic [4:0] rs, input logic [31:0] exp, input string name);
        logic [31:0] addr;
        addr = SLOT_BASE + 4 * chk_exp.size();
        emit(enc_s(addr, rs, 5'd0, 3'b010));
        expect_word(addr, exp, name);
    endtask

    task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp,
                          input string name);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, exp, name);
    endtask

    task automatic build_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc_now;
        a = 32'h8000_1234;
        b = 32'hffff_fff9;
        emit({20'h80001, 5'd1, OPC_LUI});
        emit(enc_i(32'h234, 5'd1, 3'b000, 5'd1, OPC_OPIMM));
        emit(enc_i(-7, 5'd0, 3'b000, 5'd2, OPC_OPIMM));
        alu_rr(7'h00, 3'd0, a + b, "add");
        alu_rr(7'h20, 3'd0, a - b, "sub");
        alu_rr(7'h00, 3'd1, a << b[4:0], "sll");
        alu_rr(7'h00, 3'd2, $signed(a) < $signed(b), "slt");
        alu_rr(7'h00, 3'd3, a < b, "sltu");
        alu_rr(7'h00, 3'd4, a ^ b, "xor");
        alu_rr(7'h00, 3'd5, a >> b[4:0], "srl");
        alu_rr(7'h20, 3'd5, $signed(a) >>> b[4:0], "sra");
        alu_rr(7'h00, 3'd6, a | b, "or");
        alu_rr(7'h00, 3'd7, a & b, "and");
        emit(enc_i(-100, 5'd1, 3'b000, 5'd3, OPC_OPIMM));
        store_result(5'd3, a - 100, "addi");
        emit(enc_i({7'h20, 5'd4}, 5'd1, 3'b101, 5'd3, OPC_OPIMM));
        store_result(5'd3, $signed(a) >>> 4, "srai");
        // Negative a against a small positive bound tells signed from unsigned
        emit(enc_i(5, 5'd1, 3'b010, 5'd3, OPC_OPIMM));
        store_result(5'd3, $signed(a) < 32'sd5, "slti");
        emit(enc_i(5, 5'd1, 3'b011, 5'd3, OPC_OPIMM));
        store_result(5'd3, a < 32'd5, "sltiu");
        emit(enc_i(32'h0f0, 5'd1, 3'b111, 5'd3, OPC_OPIMM));
        store_result(5'd3, a & 32'h0f0, "andi");
        emit({20'habcde, 5'd3, OPC_LUI});
        store_result(5'd3, 32'habcd_e000, "lui");
        pc_now = 4 * prog.size();
        emit({20'h00010, 5'd3, OPC_AUIPC});
        store_result(5'd3, pc_now + 32'h0001_0000, "auipc");
        emit(ECALL);
    endtask

    task automatic build_loads();
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 != 3) begin
                for (int off = 0; off < 4; off += (1 << f3[1:0])) begin
                    emit(enc_i(LOAD_ADDR + off, 5'd0, f3[2:0], 5'd3, OPC_LOAD));
                    store_result(5'd3, load_value(LOAD_WORD, off, f3[2:0]),
                                 $sformatf("load f3=%0d off=%0d", f3, off));
                end
            end
        end
        emit(ECALL);
    endtask

    task automatic build_stores();
        logic [31:0] addr;
        logic [31:0] w;
        emit({20'h11223, 5'd5, OPC_LUI});
        emit(enc_i(32'h3c4, 5'd5, 3'b000, 5'd5, OPC_OPIMM));
        for (int k = 0; k < 6; k++) begin
            addr = STORE_BASE + 4 * k;
            w = fill_word(addr[9:2]);
            if (k < 4) begin
                emit(enc_s(addr + k, 5'd5, 5'd0, 3'b000));
                w[8*k +: 8] = 8'hc4;
            end else begin
                emit(enc_s(addr + 2 * (k - 4), 5'd5, 5'd0, 3'b001));
                w[32*(k-4) - 16*(k-4) +: 16] = 16'h33c4;
            end
            expect_word(addr, w, $sformatf("store word %0d", k));
        end
        emit(ECALL);
    endtask

    task automatic build_control();
        logic [31:0] vals [1:2];
        logic [31:0] p;
        logic [2:0]  f3s [6];
        int          pairs [3][2];
        vals[1] = -7;
        vals[2] = 5;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pairs = '{'{1, 2}, '{2, 1}, '{1, 1}};
        emit(enc_i(-7, 5'd0, 3'b000, 5'd1, OPC_OPIMM));
        emit(enc_i(5, 5'd0, 3'b000, 5'd2, OPC_OPIMM));
        // A taken branch skips the second write, leaving 1 in x3
        foreach (f3s[i]) begin
            for (int j = 0; j < 3; j++) begin
                emit(enc_i(1, 5'd0, 3'b000, 5'd3, OPC_OPIMM));
                emit(enc_b(8, pairs[j][0], pairs[j][1], f3s[i]));
                emit(enc_i(2, 5'd0, 3'b000, 5'd3, OPC_OPIMM));
                store_result(5'd3,
                    branch_rule(f3s[i], vals[pairs[j][0]], vals[pairs[j][1]]) ? 1 : 2,
                    $sformatf("branch f3=%0d x%0d,x%0d", f3s[i], pairs[j][0], pairs[j][1]));
            end
        end
        // Five passes adding 3 each
        emit(enc_i(0, 5'd0, 3'b000, 5'd4, OPC_OPIMM));
        emit(enc_i(5, 5'd0, 3'b000, 5'd6, OPC_OPIMM));
        emit(enc_i(3, 5'd4, 3'b000, 5'd4, OPC_OPIMM));
        emit(enc_i(-1, 5'd6, 3'b000, 5'd6, OPC_OPIMM));
        emit(enc_b(-8, 5'd6, 5'd0, 3'b001));
        store_result(5'd4, 32'd15, "loop count");
        // JAL to a routine that returns with JALR on an odd target
        p = 4 * prog.size();
        emit(enc_j(12, 5'd1));
        emit(enc_j(16, 5'd0));
        emit(enc_i(99, 5'd0, 3'b000, 5'd8, OPC_OPIMM));
        emit(enc_i(40, 5'd0, 3'b000, 5'd8, OPC_OPIMM));
        emit(enc_i(1, 5'd1, 3'b000, 5'd9, OPC_JALR));
        store_result(5'd1, p + 4, "jal link");
        store_result(5'd9, p + 20, "jalr link");
        store_result(5'd8, 32'd40, "routine value");
        emit(ECALL);
    endtask

    task automatic run_program(input string title, input logic [1:0] waits, input int idle);
        int          errs_before;
        logic [31:0] got;
        errs_before = total_errors();
        @(negedge clk_i);
        rst_n_i = 1'b0;
        max_wait = waits;
        for (int i = 0; i < 256; i++) begin
            wb_mem_model_inst.mem[i] = fill_word(i[7:0]);
        end
        foreach (prog[i]) begin
            wb_mem_model_inst.mem[i] = prog[i];
        end
        wb_mem_model_inst.mem[LOAD_ADDR[9:2]] = LOAD_WORD;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        wait (halt_o === 1'b1);
        // The core must stay off the bus once halted
        repeat (idle) begin
            @(negedge clk_i);
            assert (wb_cyc === 1'b0) else begin
                $display("Bus cycle started after halt at %0t ns", $time);
                err_count++;
            end
        end
        @(negedge clk_i);
        foreach (chk_addr[i]) begin
            got = wb_mem_model_inst.mem[chk_addr[i][9:2]];
            assert (got === chk_exp[i]) else begin
                $display("** Error at %0t ns: %s = %h, expected %h",
                         $time, chk_name[i], got, chk_exp[i]);
                err_count++;
            end
        end
        if (total_errors() == errs_before) begin
            pass_tests++;
            $display("Test %s: passed, %0d words", title, chk_addr.size());
        end else begin
            fail_tests++;
            $display("Test %s: failed, %0d errors", title, total_errors() - errs_before);
        end
        prog.delete();
        chk_addr.delete();
        chk_exp.delete();
        chk_name.delete();
    endtask

    initial begin
        rst_n_i = 1'b0;
        max_wait = 2'd0;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        build_arith();
        run_program("arithmetic", 2'd0, 0);
        build_loads();
        run_program("loads", 2'd0, 0);
        build_stores();
        run_program("stores", 2'd0, 0);
        build_control();
        run_program("control flow", 2'd0, 0);
        build_arith();
        run_program("wait states", 2'd3, 20);
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_tests, fail_tests, total_errors());
        if (fail_tests == 0 && total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_control.sv
rtl/rv_core_top.sv
verification/wb_mem_model.sv
verification/rv_core_checker.sv
verification/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_lsu.sv
  - rtl/rv_control.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - verification/wb_mem_model.sv
      - verification/rv_core_checker.sv
      - verification/tb_rv_core.sv
